// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f toy_correlator.f --top-module tb_toy_correlator -o sim_tb

out=$(./obj_dir/sim_tb 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "Simulation finished: PASS"; then
  exit 0
else
  exit 1
fi

// File: source/baseline_correlator.sv
`timescale 1ns/100ps
module baseline_correlator (
  input  logic              vis_clock,
  input  logic              vis_reset,
  input  corr_pkg::tap_t    tap_i,
  output corr_pkg::psum_t   psum_o,
  output logic              psum_valid_o
);
  import corr_pkg::*;

  logic signed [psum_bits-1:0] re_sum [num_slots];
  logic signed [psum_bits-1:0] im_sum [num_slots];

  logic [1:0]                  ant_a;
  logic [1:0]                  ant_b;
  logic                        ia;
  logic                        qa;
  logic                        ib;
  logic                        qb;
  logic signed [psum_bits-1:0] re_term;
  logic signed [psum_bits-1:0] im_term;
  logic signed [psum_bits-1:0] re_acc;
  logic signed [psum_bits-1:0] im_acc;

  // Sign bit to +1 / -1
  function automatic logic signed [psum_bits-1:0] pm(input logic b);
    return b ? psum_bits'(1) : psum_bits'(-1);
  endfunction

  // Baseline lookup, two bits per slot
  assign ant_a = ant_a_tab[{tap_i.slot, 1'b0} +: 2];
  assign ant_b = ant_b_tab[{tap_i.slot, 1'b0} +: 2];

  assign ia = tap_i.sample.idata[ant_a];
  assign qa = tap_i.sample.qdata[ant_a];
  assign ib = tap_i.sample.idata[ant_b];
  assign qb = tap_i.sample.qdata[ant_b];

  // a * conj(b)
  assign re_term = pm(ia ~^ ib) + pm(qa ~^ qb);
  assign im_term = pm(qa ~^ ib) - pm(ia ~^ qb);

  // First tap of a block restarts the sum
  assign re_acc = tap_i.first ? re_term : re_sum[tap_i.slot] + re_term;
  assign im_acc = tap_i.first ? im_term : im_sum[tap_i.slot] + im_term;

  always_ff @(posedge vis_clock) begin
    if (tap_i.valid) begin
      re_sum[tap_i.slot] <= re_acc;
      im_sum[tap_i.slot] <= im_acc;
    end
    if (tap_i.valid && tap_i.last) begin
      psum_o.slot <= tap_i.slot;
      psum_o.re   <= re_acc;
      psum_o.im   <= im_acc;
    end
  end

  always_ff @(posedge vis_clock) begin
    if (vis_reset) begin
      psum_valid_o <= 1'b0;
    end else begin
      psum_valid_o <= tap_i.valid && tap_i.last;
    end
  end

endmodule

// File: source/corr_pkg.sv
package corr_pkg;

  // Array geometry
  localparam int num_ant      = 4;
  localparam int num_slots    = 8;   // 6 cross + 2 auto baselines
  localparam int slot_bits    = 3;
  localparam int block_len    = 15;  // Samples per partial sum
  localparam int sample_bits  = 4;
  localparam int frame_blocks = 4;   // Blocks per visibility frame
  localparam int frame_bits   = 2;

  // Accumulator widths
  localparam int psum_bits = 7;   // Holds +/-30
  localparam int acc_bits  = 32;

  // Antenna pair per slot, slot 0 in the low bits
  // Pairs are (0,1) (0,2) (0,3) (1,2) (1,3) (2,3) (0,0) (1,1)
  localparam logic [15:0] ant_a_tab = {2'd1, 2'd0, 2'd2, 2'd1, 2'd1, 2'd0, 2'd0, 2'd0};
  localparam logic [15:0] ant_b_tab = {2'd1, 2'd0, 2'd3, 2'd3, 2'd2, 2'd3, 2'd2, 2'd1};

  // One-bit I/Q signs of all antennas
  typedef struct packed {
    logic [num_ant-1:0] idata;
    logic [num_ant-1:0] qdata;
  } sample_t;

  // Replayed sample for one baseline slot
  typedef struct packed {
    logic                 valid;
    logic                 first;  // Sample 0 of the block
    logic                 last;   // Sample 14 of the block
    logic [slot_bits-1:0] slot;
    sample_t              sample;
  } tap_t;

  typedef struct packed {
    logic [slot_bits-1:0]        slot;
    logic signed [psum_bits-1:0] re;
    logic signed [psum_bits-1:0] im;
  } psum_t;

  typedef struct packed {
    logic [slot_bits-1:0]       slot;
    logic signed [acc_bits-1:0] re;
    logic signed [acc_bits-1:0] im;
  } vis_t;

  typedef enum logic [1:0] {
    seq_idle,
    seq_replay,
    seq_wait
  } seq_state_e;

endpackage

// File: source/replay_sequencer.sv
`timescale 1ns/100ps
module replay_sequencer (
  input  logic vis_clock,
  input  logic vis_reset,
  input  logic bank_ready_i,
  input  logic block_last_i,
  output logic cnt_run_o,
  output logic busy_o,
  output logic start_o,
  output logic frame_o
);
  import corr_pkg::*;

  seq_state_e state;
  seq_state_e state_nxt;
  logic       accept;

  // A new bank is only taken while idle
  assign accept = (state == seq_idle) && bank_ready_i;

  always_comb begin
    state_nxt = state;
    case (state)
      seq_idle: begin
        if (bank_ready_i) begin
          state_nxt = seq_replay;
        end
      end
      seq_replay: begin
        if (block_last_i) begin
          state_nxt = seq_wait;  // 120 counter steps done
        end
      end
      seq_wait: begin
        state_nxt = seq_idle;    // Last tap drains here
      end
      default: begin
        state_nxt = seq_idle;
      end
    endcase
  end

  always_ff @(posedge vis_clock) begin
    if (vis_reset) begin
      state   <= seq_idle;
      start_o <= 1'b0;
      frame_o <= 1'b0;
    end else begin
      state   <= state_nxt;
      start_o <= accept && !frame_o;  // Only the first replay after reset
      if (accept) begin
        frame_o <= 1'b1;
      end
    end
  end

  assign cnt_run_o = (state == seq_replay);
  // Any block completing now could not be accepted next cycle
  assign busy_o    = (state == seq_replay);

endmodule

// File: source/sample_buffer.sv
`timescale 1ns/100ps
module sample_buffer (
  input  logic                             vis_clock,
  input  logic                             vis_reset,
  input  logic                             sig_valid_i,
  input  corr_pkg::sample_t                sig_i,
  input  logic                             busy_i,
  input  logic [corr_pkg::slot_bits-1:0]   slot_i,
  input  logic [corr_pkg::sample_bits-1:0] sample_idx_i,
  input  logic                             first_i,
  input  logic                             last_i,
  input  logic                             run_i,
  output logic                             bank_ready_o,
  output logic                             overrun_o,
  output corr_pkg::tap_t                   tap_o
);
  import corr_pkg::*;

  sample_t                mem [0:1][0:block_len-1];
  logic [sample_bits-1:0] wr_ptr;
  logic                   wr_bank;
  logic                   rd_bank;
  logic                   wr_wrap;

  assign rd_bank = ~wr_bank;  // Replay always uses the idle bank
  assign wr_wrap = sig_valid_i && (wr_ptr == sample_bits'(block_len - 1));

  always_ff @(posedge vis_clock) begin
    if (sig_valid_i) begin
      mem[wr_bank][wr_ptr] <= sig_i;
    end
  end

  always_ff @(posedge vis_clock) begin
    if (vis_reset) begin
      wr_ptr       <= '0;
      wr_bank      <= 1'b0;
      bank_ready_o <= 1'b0;
      overrun_o    <= 1'b0;
    end else begin
      bank_ready_o <= wr_wrap;
      if (sig_valid_i) begin
        wr_ptr <= wr_wrap ? '0 : wr_ptr + 1'b1;
      end
      // A block that completes during a replay is overwritten in place
      if (wr_wrap) begin
        if (busy_i) begin
          overrun_o <= 1'b1;  // Sticky
        end else begin
          wr_bank <= ~wr_bank;
        end
      end
    end
  end

  // Read port, one cycle behind the slot counter
  always_ff @(posedge vis_clock) begin
    tap_o.first  <= first_i;
    tap_o.last   <= last_i;
    tap_o.slot   <= slot_i;
    tap_o.sample <= mem[rd_bank][sample_idx_i];
    if (vis_reset) begin
      tap_o.valid <= 1'b0;
    end else begin
      tap_o.valid <= run_i;
    end
  end

endmodule

// File: source/slot_counter.sv
`timescale 1ns/100ps
module slot_counter (
  input  logic                             vis_clock,
  input  logic                             vis_reset,
  input  logic                             run_i,
  output logic [corr_pkg::slot_bits-1:0]   slot_o,
  output logic [corr_pkg::sample_bits-1:0] sample_idx_o,
  output logic                             first_o,
  output logic                             last_o,
  output logic                             block_last_o
);
  import corr_pkg::*;

  logic slot_wrap;

  assign slot_wrap = (slot_o == slot_bits'(num_slots - 1));

  // Slot is the fast index, sample the slow one
  always_ff @(posedge vis_clock) begin
    if (vis_reset || !run_i) begin
      slot_o       <= '0;
      sample_idx_o <= '0;
    end else if (slot_wrap) begin
      slot_o       <= '0;
      sample_idx_o <= last_o ? '0 : sample_idx_o + 1'b1;
    end else begin
      slot_o <= slot_o + 1'b1;
    end
  end

  assign first_o      = (sample_idx_o == '0);
  assign last_o       = (sample_idx_o == sample_bits'(block_len - 1));
  assign block_last_o = last_o && slot_wrap;  // Final tap of the replay

endmodule

// File: source/toy_correlator.sv
`timescale 1ns/100ps
module toy_correlator (
  input  logic              vis_clock,
  input  logic              vis_reset,
  input  logic              sig_valid_i,
  input  corr_pkg::sample_t sig_i,
  output logic              vis_start_o,
  output logic              vis_frame_o,
  output logic              vis_valid_o,
  output logic              vis_last_o,
  output logic              overrun_o,
  output corr_pkg::vis_t    vis_o
);
  import corr_pkg::*;

  logic                   bank_ready;
  logic                   busy;
  logic                   cnt_run;
  logic                   block_last;
  logic [slot_bits-1:0]   slot;
  logic [sample_bits-1:0] sample_idx;
  logic                   slot_first;
  logic                   slot_last;
  tap_t                   tap;
  psum_t                  psum;
  logic                   psum_valid;

  sample_buffer u_buffer (
    .vis_clock   (vis_clock),
    .vis_reset   (vis_reset),
    .sig_valid_i (sig_valid_i),
    .sig_i       (sig_i),
    .busy_i      (busy),
    .slot_i      (slot),
    .sample_idx_i(sample_idx),
    .first_i     (slot_first),
    .last_i      (slot_last),
    .run_i       (cnt_run),
    .bank_ready_o(bank_ready),
    .overrun_o   (overrun_o),
    .tap_o       (tap)
  );

  replay_sequencer u_seq (
    .vis_clock   (vis_clock),
    .vis_reset   (vis_reset),
    .bank_ready_i(bank_ready),
    .block_last_i(block_last),
    .cnt_run_o   (cnt_run),
    .busy_o      (busy),
    .start_o     (vis_start_o),
    .frame_o     (vis_frame_o)
  );

  slot_counter u_count (
    .vis_clock   (vis_clock),
    .vis_reset   (vis_reset),
    .run_i       (cnt_run),
    .slot_o      (slot),
    .sample_idx_o(sample_idx),
    .first_o     (slot_first),
    .last_o      (slot_last),
    .block_last_o(block_last)
  );

  baseline_correlator u_corr (
    .vis_clock   (vis_clock),
    .vis_reset   (vis_reset),
    .tap_i       (tap),
    .psum_o      (psum),
    .psum_valid_o(psum_valid)
  );

  vis_accumulator u_accum (
    .vis_clock   (vis_clock),
    .vis_reset   (vis_reset),
    .psum_i      (psum),
    .psum_valid_i(psum_valid),
    .vis_o       (vis_o),
    .vis_valid_o (vis_valid_o),
    .vis_last_o  (vis_last_o)
  );

endmodule

// File: source/vis_accumulator.sv
`timescale 1ns/100ps
module vis_accumulator (
  input  logic             vis_clock,
  input  logic             vis_reset,
  input  corr_pkg::psum_t  psum_i,
  input  logic             psum_valid_i,
  output corr_pkg::vis_t   vis_o,
  output logic             vis_valid_o,
  output logic             vis_last_o
);
  import corr_pkg::*;

  logic signed [acc_bits-1:0] acc_re [num_slots];
  logic signed [acc_bits-1:0] acc_im [num_slots];

  logic [frame_bits-1:0]      blk;        // Block within the frame
  logic                       blk_first;
  logic                       blk_last;
  logic                       slot_last;
  logic signed [acc_bits-1:0] re_ext;
  logic signed [acc_bits-1:0] im_ext;
  logic signed [acc_bits-1:0] re_new;
  logic signed [acc_bits-1:0] im_new;

  assign blk_first = (blk == '0);
  assign blk_last  = (blk == frame_bits'(frame_blocks - 1));
  assign slot_last = (psum_i.slot == slot_bits'(num_slots - 1));

  // Sign extension of the partial sums
  assign re_ext = {{(acc_bits - psum_bits){psum_i.re[psum_bits-1]}}, psum_i.re};
  assign im_ext = {{(acc_bits - psum_bits){psum_i.im[psum_bits-1]}}, psum_i.im};

  assign re_new = blk_first ? re_ext : acc_re[psum_i.slot] + re_ext;
  assign im_new = blk_first ? im_ext : acc_im[psum_i.slot] + im_ext;

  always_ff @(posedge vis_clock) begin
    if (psum_valid_i) begin
      acc_re[psum_i.slot] <= re_new;
      acc_im[psum_i.slot] <= im_new;
    end
    if (psum_valid_i && blk_last) begin
      vis_o.slot <= psum_i.slot;
      vis_o.re   <= re_new;
      vis_o.im   <= im_new;
    end
  end

  always_ff @(posedge vis_clock) begin
    if (vis_reset) begin
      blk         <= '0;
      vis_valid_o <= 1'b0;
      vis_last_o  <= 1'b0;
    end else begin
      vis_valid_o <= psum_valid_i && blk_last;
      vis_last_o  <= psum_valid_i && blk_last && slot_last;
      if (psum_valid_i && slot_last) begin
        blk <= blk_last ? '0 : blk + 1'b1;  // Next block after slot 7
      end
    end
  end

endmodule

// File: test/tb_toy_correlator.sv
`timescale 1ns/100ps
module tb_toy_correlator;
  import corr_pkg::*;

  localparam int main_blocks  = 6 * frame_blocks;  // Six frames
  localparam int burst_blocks = 3;
  localparam int stim_cycles  = main_blocks * block_len * 12
                              + burst_blocks * block_len * 2 + 200;
  localparam int cycle_limit  = stim_cycles + 500;

  logic    vis_clock;
  logic    vis_reset;
  logic    sig_valid_i;
  sample_t sig_i;
  logic    vis_start_o;
  logic    vis_frame_o;
  logic    vis_valid_o;
  logic    vis_last_o;
  logic    overrun_o;
  vis_t    vis_o;

  // Antenna pairs of slots 0 to 7
  int pair_a [num_slots] = '{0, 0, 0, 1, 1, 2, 0, 1};
  int pair_b [num_slots] = '{1, 2, 3, 2, 3, 3, 0, 1};

  sample_t blk_q [$];
  vis_t    exp_q [$];
  int      frame_re [num_slots];
  int      frame_im [num_slots];
  int      blocks_done;
  int      sent;
  int      cycles;
  bit      start_seen;
  bit      overrun_seen;
  bit      burst_on;

  toy_correlator dut0 (
    .vis_clock  (vis_clock),
    .vis_reset  (vis_reset),
    .sig_valid_i(sig_valid_i),
    .sig_i      (sig_i),
    .vis_start_o(vis_start_o),
    .vis_frame_o(vis_frame_o),
    .vis_valid_o(vis_valid_o),
    .vis_last_o (vis_last_o),
    .overrun_o  (overrun_o),
    .vis_o      (vis_o)
  );

  initial begin
    vis_clock = 1'b0;
    forever #4 vis_clock = ~vis_clock;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_vis(input vis_t got, input vis_t exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH at %0t: vis_o got (%0d, %0d, %0d) expected (%0d, %0d, %0d)",
                          $time, got.slot, got.re, got.im, exp.slot, exp.re, exp.im));
    end
  endtask

  function automatic int sign_val(input logic b);
    return b ? 1 : -1;  // Bit 1 is +1
  endfunction

  // Fold a full block into the frame sums, queue results after the fourth
  task automatic model_block();
    int   re;
    int   im;
    int   a;
    int   b;
    vis_t v;
    for (int s = 0; s < num_slots; s++) begin
      a  = pair_a[s];
      b  = pair_b[s];
      re = 0;
      im = 0;
      foreach (blk_q[n]) begin
        re += sign_val(blk_q[n].idata[a]) * sign_val(blk_q[n].idata[b])
            + sign_val(blk_q[n].qdata[a]) * sign_val(blk_q[n].qdata[b]);
        im += sign_val(blk_q[n].qdata[a]) * sign_val(blk_q[n].idata[b])
            - sign_val(blk_q[n].idata[a]) * sign_val(blk_q[n].qdata[b]);
      end
      frame_re[s] = (blocks_done % frame_blocks == 0) ? re : frame_re[s] + re;
      frame_im[s] = (blocks_done % frame_blocks == 0) ? im : frame_im[s] + im;
    end
    blk_q.delete();
    blocks_done++;
    if (blocks_done % frame_blocks == 0) begin
      for (int s = 0; s < num_slots; s++) begin
        v.slot = 3'(s);
        v.re   = frame_re[s];
        v.im   = frame_im[s];
        exp_q.push_back(v);
      end
    end
  endtask

  // One strobe, then idle until the next strobe is due
  task automatic drive_sample(input int spacing, input bit modeled);
    sample_t smp;
    smp = sample_t'(8'($urandom));
    @(posedge vis_clock);
    sig_valid_i <= 1'b1;
    sig_i       <= smp;
    sent++;
    if (modeled) begin
      blk_q.push_back(smp);
      if (blk_q.size() == block_len) begin
        model_block();
      end
    end
    @(posedge vis_clock);
    sig_valid_i <= 1'b0;
    repeat (spacing - 2) @(posedge vis_clock);
  endtask

  initial begin
    void'($urandom(32'he1a982b6));
    vis_reset    = 1'b1;
    sig_valid_i  = 1'b0;
    sig_i        = '0;
    blocks_done  = 0;
    sent         = 0;
    cycles       = 0;
    start_seen   = 1'b0;
    overrun_seen = 1'b0;
    burst_on     = 1'b0;
    repeat (2) @(posedge vis_clock);
    vis_reset <= 1'b0;
    for (int n = 0; n < main_blocks * block_len; n++) begin
      drive_sample($urandom_range(12, 9), 1'b1);
    end
    while (exp_q.size() != 0) @(posedge vis_clock);  // Last frame drains
    repeat (20) @(posedge vis_clock);
    burst_on = 1'b1;
    for (int n = 0; n < burst_blocks * block_len; n++) begin
      drive_sample(2, 1'b0);  // Far too fast for a 120 cycle replay
    end
    repeat (150) @(posedge vis_clock);
    if (!start_seen) begin
      abort_run("vis_start_o never pulsed");
    end else if (!overrun_seen) begin
      abort_run("overrun_o was not set by the fast burst");
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

  // Outputs sampled on the falling edge
  always @(negedge vis_clock) begin
    vis_t exp_v;
    vis_t auto_v;
    if (!vis_reset) begin
      if (sent < block_len) begin
        check_bit("vis_start_o", vis_start_o, 1'b0);
        check_bit("vis_valid_o", vis_valid_o, 1'b0);
        check_bit("vis_last_o", vis_last_o, 1'b0);
        check_bit("overrun_o", overrun_o, 1'b0);
      end
      if (vis_start_o && start_seen) begin
        abort_run("vis_start_o pulsed a second time");
      end else if (vis_start_o) begin
        start_seen = 1'b1;
      end
      check_bit("vis_frame_o", vis_frame_o, start_seen);
      if (!burst_on) begin
        check_bit("overrun_o", overrun_o, 1'b0);
      end else if (overrun_seen) begin
        check_bit("overrun_o", overrun_o, 1'b1);  // Must stay set
      end
      if (overrun_o) begin
        overrun_seen = 1'b1;
      end
      if (vis_valid_o && exp_q.size() == 0) begin
        abort_run($sformatf("Unexpected visibility for slot %0d at %0t", vis_o.slot, $time));
      end else if (vis_valid_o) begin
        exp_v = exp_q.pop_front();
        if (exp_v.slot >= 3'd6) begin
          auto_v.slot = exp_v.slot;
          auto_v.re   = 2 * block_len * frame_blocks;  // Autocorrelation power
          auto_v.im   = 0;
          check_vis(vis_o, auto_v);
        end else begin
          check_vis(vis_o, exp_v);
        end
        check_bit("vis_last_o", vis_last_o, exp_v.slot == 3'd7);
      end else begin
        check_bit("vis_last_o", vis_last_o, 1'b0);
      end
    end
  end

  always @(posedge vis_clock) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      abort_run($sformatf("Timeout after %0d cycles with the sequencer in %s",
                          cycles, dut0.u_seq.state.name()));
    end
  end

endmodule

// File: toy_correlator.f
source/corr_pkg.sv
source/sample_buffer.sv
source/slot_counter.sv
source/replay_sequencer.sv
source/baseline_correlator.sv
source/vis_accumulator.sv
source/toy_correlator.sv
test/tb_toy_correlator.sv
